/* hdl/ooo_config_pkg.sv */
package ooo_config_pkg;

    // datapath
    localparam int data_width = 32;

    // architectural registers, reset value of register i is i
    localparam int num_arch_regs = 8;
    localparam int reg_idx_width = 3;

    // result tags stand in for physical registers
    localparam int num_tags  = 16;
    localparam int tag_width = 4;  // must cover num_tags

    // reservation station
    localparam int rs_size        = 8;
    localparam int rs_count_width = 4;  // holds 0..rs_size
    localparam int alert_depth    = 1;  // almost_full at count > rs_size - alert_depth

    // multiplier stages from issue to the cdb
    localparam int mult_latency = 3;

endpackage

/* hdl/ooo_isa_pkg.sv */
package ooo_isa_pkg;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_xor = 3'd3,
        op_mul = 3'd4
    } opcode_t;

    // which unit executes an opcode
    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_class_t;

    function automatic fu_class_t fu_class_of(input opcode_t op);
        fu_class_t cls;
        case (op)
            op_mul:  cls = fu_mult;
            default: cls = fu_alu;  // add, sub, and, xor
        endcase
        return cls;
    endfunction

endpackage

/* hdl/dispatch_stage.sv */
module dispatch_stage (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     inst_valid,
    input  ooo_isa_pkg::opcode_t                     inst_op,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] inst_dest,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] inst_src1,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] inst_src2,
    input  logic                                     almost_full,
    input  logic                                     cdb_valid,
    input  logic [ooo_config_pkg::tag_width-1:0]     cdb_tag,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] cdb_dest,
    input  logic [ooo_config_pkg::data_width-1:0]    cdb_value,
    output logic                                     stall,
    output logic                                     disp_valid,
    output ooo_isa_pkg::opcode_t                     disp_op,
    output logic [ooo_config_pkg::reg_idx_width-1:0] disp_dest,
    output logic [ooo_config_pkg::tag_width-1:0]     disp_tag,
    output logic                                     src1_ready,
    output logic [ooo_config_pkg::data_width-1:0]    src1_value,
    output logic                                     src2_ready,
    output logic [ooo_config_pkg::data_width-1:0]    src2_value
);
    import ooo_config_pkg::*;
    import ooo_isa_pkg::*;

    logic [data_width-1:0] regs [num_arch_regs];
    logic [num_arch_regs-1:0] pending;       // register waits on a tag
    logic [tag_width-1:0] producer [num_arch_regs];  // youngest writer
    logic [num_tags-1:0] tag_busy;
    logic [tag_width-1:0] next_tag;
    logic accept;

    // ready value from the register file, the cdb, or the waiting tag
    function automatic void read_source(
        input  logic [reg_idx_width-1:0] idx,
        output logic                     ready,
        output logic [data_width-1:0]    value
    );
        if (!pending[idx]) begin
            ready = 1'b1;
            value = regs[idx];
        end else if (cdb_valid && cdb_tag == producer[idx]) begin
            ready = 1'b1;  // result arrives this very cycle
            value = cdb_value;
        end else begin
            ready = 1'b0;
            value = {{(data_width - tag_width){1'b0}}, producer[idx]};
        end
    endfunction

    assign stall  = almost_full || tag_busy[next_tag];  // station full or tag still in flight
    assign accept = inst_valid && !stall;

    assign disp_valid = accept;
    assign disp_op    = inst_op;
    assign disp_dest  = inst_dest;
    assign disp_tag   = next_tag;

    always_comb begin
        read_source(inst_src1, src1_ready, src1_value);
        read_source(inst_src2, src2_ready, src2_value);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_arch_regs; i++) begin
                regs[i] <= data_width'(i);
            end
            pending  <= '0;
            tag_busy <= '0;
            next_tag <= '0;
        end else begin
            if (cdb_valid) begin
                tag_busy[cdb_tag] <= 1'b0;
                // stale results from older writers are dropped
                if (pending[cdb_dest] && producer[cdb_dest] == cdb_tag) begin
                    regs[cdb_dest]    <= cdb_value;
                    pending[cdb_dest] <= 1'b0;
                end
            end
            if (accept) begin  // later than the cdb clear on purpose
                pending[inst_dest] <= 1'b1;
                tag_busy[next_tag] <= 1'b1;
                next_tag <= (next_tag == tag_width'(num_tags - 1)) ? '0 : next_tag + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            producer[inst_dest] <= next_tag;
        end
    end

endmodule

/* hdl/reservation_station.sv */
module reservation_station (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     disp_valid,
    input  ooo_isa_pkg::opcode_t                     disp_op,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] disp_dest,
    input  logic [ooo_config_pkg::tag_width-1:0]     disp_tag,
    input  logic                                     src1_ready,
    input  logic [ooo_config_pkg::data_width-1:0]    src1_value,
    input  logic                                     src2_ready,
    input  logic [ooo_config_pkg::data_width-1:0]    src2_value,
    input  logic                                     alu_avail,
    input  logic                                     cdb_valid,
    input  logic [ooo_config_pkg::tag_width-1:0]     cdb_tag,
    input  logic [ooo_config_pkg::data_width-1:0]    cdb_value,
    output logic                                     almost_full,
    output logic                                     alu_issue,
    output ooo_isa_pkg::opcode_t                     alu_op,
    output logic [ooo_config_pkg::data_width-1:0]    alu_a,
    output logic [ooo_config_pkg::data_width-1:0]    alu_b,
    output logic [ooo_config_pkg::tag_width-1:0]     alu_tag,
    output logic [ooo_config_pkg::reg_idx_width-1:0] alu_dest,
    output logic                                     mult_issue,
    output logic [ooo_config_pkg::data_width-1:0]    mult_a,
    output logic [ooo_config_pkg::data_width-1:0]    mult_b,
    output logic [ooo_config_pkg::tag_width-1:0]     mult_tag,
    output logic [ooo_config_pkg::reg_idx_width-1:0] mult_dest
);
    import ooo_config_pkg::*;
    import ooo_isa_pkg::*;

    typedef logic [$clog2(rs_size)-1:0] rs_idx_t;

    // entry storage
    logic [rs_size-1:0] e_valid;
    logic [rs_size-1:0] e_r1;
    logic [rs_size-1:0] e_r2;
    opcode_t e_op [rs_size];
    logic [reg_idx_width-1:0] e_dest [rs_size];
    logic [tag_width-1:0] e_tag [rs_size];
    logic [data_width-1:0] e_v1 [rs_size];  // value, or tag while waiting
    logic [data_width-1:0] e_v2 [rs_size];

    logic [rs_count_width-1:0] count;

    logic [rs_size-1:0] ins_sel;
    logic [rs_size-1:0] alu_req, mult_req;
    logic [rs_size-1:0] alu_grant, mult_grant;
    rs_idx_t alu_idx, mult_idx;
    logic in_r1, in_r2;
    logic [data_width-1:0] in_v1, in_v2;

    // lowest set bit wins
    function automatic logic [rs_size-1:0] first_set(input logic [rs_size-1:0] req);
        return req & ~(req - 1'b1);
    endfunction

    function automatic logic cdb_hit(input logic ready, input logic [data_width-1:0] value);
        return cdb_valid && !ready && value[tag_width-1:0] == cdb_tag;
    endfunction

    // incoming operands also snoop the cdb
    always_comb begin
        in_r1 = src1_ready || cdb_hit(src1_ready, src1_value);
        in_v1 = cdb_hit(src1_ready, src1_value) ? cdb_value : src1_value;
        in_r2 = src2_ready || cdb_hit(src2_ready, src2_value);
        in_v2 = cdb_hit(src2_ready, src2_value) ? cdb_value : src2_value;
    end

    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            alu_req[i]  = e_valid[i] && e_r1[i] && e_r2[i] && fu_class_of(e_op[i]) == fu_alu;
            mult_req[i] = e_valid[i] && e_r1[i] && e_r2[i] && fu_class_of(e_op[i]) == fu_mult;
        end
        ins_sel    = first_set(~e_valid) & {rs_size{disp_valid}};
        alu_grant  = first_set(alu_req) & {rs_size{alu_avail}};  // alu busy on mult writeback
        mult_grant = first_set(mult_req);
        alu_idx  = '0;
        mult_idx = '0;
        for (int i = 0; i < rs_size; i++) begin
            if (alu_grant[i]) alu_idx = rs_idx_t'(i);
            if (mult_grant[i]) mult_idx = rs_idx_t'(i);
        end
    end

    assign alu_issue = |alu_grant;
    assign alu_op    = e_op[alu_idx];
    assign alu_a     = e_v1[alu_idx];
    assign alu_b     = e_v2[alu_idx];
    assign alu_tag   = e_tag[alu_idx];
    assign alu_dest  = e_dest[alu_idx];

    assign mult_issue = |mult_grant;
    assign mult_a     = e_v1[mult_idx];
    assign mult_b     = e_v2[mult_idx];
    assign mult_tag   = e_tag[mult_idx];
    assign mult_dest  = e_dest[mult_idx];

    assign almost_full = count > rs_count_width'(rs_size - alert_depth);

    always_ff @(posedge clock) begin
        if (reset) begin
            e_valid <= '0;
            count   <= '0;
        end else begin
            for (int i = 0; i < rs_size; i++) begin
                if (ins_sel[i]) begin
                    e_valid[i] <= 1'b1;
                end else if (alu_grant[i] || mult_grant[i]) begin
                    e_valid[i] <= 1'b0;
                end
            end
            count <= count + rs_count_width'(disp_valid)
                     - rs_count_width'(alu_issue) - rs_count_width'(mult_issue);
        end
    end

    // payload and wake-up
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_size; i++) begin
            if (ins_sel[i]) begin
                e_op[i]   <= disp_op;
                e_dest[i] <= disp_dest;
                e_tag[i]  <= disp_tag;
                e_r1[i]   <= in_r1;
                e_v1[i]   <= in_v1;
                e_r2[i]   <= in_r2;
                e_v2[i]   <= in_v2;
            end else begin
                if (cdb_hit(e_r1[i], e_v1[i])) begin
                    e_r1[i] <= 1'b1;
                    e_v1[i] <= cdb_value;
                end
                if (cdb_hit(e_r2[i], e_v2[i])) begin
                    e_r2[i] <= 1'b1;
                    e_v2[i] <= cdb_value;
                end
            end
        end
    end

endmodule

/* hdl/execute_units.sv */
module execute_units (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     alu_issue,
    input  ooo_isa_pkg::opcode_t                     alu_op,
    input  logic [ooo_config_pkg::data_width-1:0]    alu_a,
    input  logic [ooo_config_pkg::data_width-1:0]    alu_b,
    input  logic [ooo_config_pkg::tag_width-1:0]     alu_tag,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] alu_dest,
    input  logic                                     mult_issue,
    input  logic [ooo_config_pkg::data_width-1:0]    mult_a,
    input  logic [ooo_config_pkg::data_width-1:0]    mult_b,
    input  logic [ooo_config_pkg::tag_width-1:0]     mult_tag,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] mult_dest,
    output logic                                     alu_avail,
    output logic                                     cdb_valid,
    output logic [ooo_config_pkg::tag_width-1:0]     cdb_tag,
    output logic [ooo_config_pkg::reg_idx_width-1:0] cdb_dest,
    output logic [ooo_config_pkg::data_width-1:0]    cdb_value
);
    import ooo_config_pkg::*;
    import ooo_isa_pkg::*;

    logic [data_width-1:0] alu_result;

    // multiplier control, one slot per registered stage
    logic [mult_latency-2:0] m_valid;
    logic [tag_width-1:0] m_tag [mult_latency-1];
    logic [reg_idx_width-1:0] m_dest [mult_latency-1];
    logic [data_width-1:0] pp_lo, pp_hi;  // partial products
    logic [data_width-1:0] product;
    logic m_last_valid;

    always_comb begin
        case (alu_op)
            op_add:  alu_result = alu_a + alu_b;
            op_sub:  alu_result = alu_a - alu_b;
            op_and:  alu_result = alu_a & alu_b;
            op_xor:  alu_result = alu_a ^ alu_b;
            default: alu_result = '0;
        endcase
    end

    assign m_last_valid = m_valid[mult_latency-2];
    assign alu_avail    = !m_last_valid;  // that stage owns the cdb next cycle

    always_ff @(posedge clock) begin
        if (reset) begin
            m_valid <= '0;
        end else begin
            m_valid <= {m_valid[mult_latency-3:0], mult_issue};
        end
    end

    always_ff @(posedge clock) begin
        m_tag[0]  <= mult_tag;
        m_dest[0] <= mult_dest;
        for (int s = 1; s < mult_latency - 1; s++) begin
            m_tag[s]  <= m_tag[s-1];
            m_dest[s] <= m_dest[s-1];
        end
        // low half and high half of b, high part only matters below bit 16
        pp_lo   <= mult_a * mult_b[data_width/2-1:0];
        pp_hi   <= mult_a * mult_b[data_width-1:data_width/2];
        product <= pp_lo + (pp_hi << (data_width / 2));
    end

    // cdb output register
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= m_last_valid || alu_issue;
        end
    end

    always_ff @(posedge clock) begin
        if (m_last_valid) begin
            cdb_tag   <= m_tag[mult_latency-2];
            cdb_dest  <= m_dest[mult_latency-2];
            cdb_value <= product;
        end else begin
            cdb_tag   <= alu_tag;
            cdb_dest  <= alu_dest;
            cdb_value <= alu_result;
        end
    end

endmodule

/* hdl/ooo_core.sv */
module ooo_core (
    input  logic                                     clock,
    input  logic                                     reset,
    input  logic                                     inst_valid,
    input  ooo_isa_pkg::opcode_t                     inst_op,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] inst_dest,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] inst_src1,
    input  logic [ooo_config_pkg::reg_idx_width-1:0] inst_src2,
    output logic                                     stall,
    output logic                                     cdb_valid,
    output logic [ooo_config_pkg::tag_width-1:0]     cdb_tag,
    output logic [ooo_config_pkg::reg_idx_width-1:0] cdb_dest,
    output logic [ooo_config_pkg::data_width-1:0]    cdb_value
);
    import ooo_config_pkg::*;
    import ooo_isa_pkg::*;

    // dispatch to station
    logic disp_valid;
    opcode_t disp_op;
    logic [reg_idx_width-1:0] disp_dest;
    logic [tag_width-1:0] disp_tag;
    logic src1_ready;
    logic [data_width-1:0] src1_value;
    logic src2_ready;
    logic [data_width-1:0] src2_value;
    logic almost_full;

    // station to execute units
    logic alu_avail;
    logic alu_issue;
    opcode_t alu_op;
    logic [data_width-1:0] alu_a;
    logic [data_width-1:0] alu_b;
    logic [tag_width-1:0] alu_tag;
    logic [reg_idx_width-1:0] alu_dest;
    logic mult_issue;
    logic [data_width-1:0] mult_a;
    logic [data_width-1:0] mult_b;
    logic [tag_width-1:0] mult_tag;
    logic [reg_idx_width-1:0] mult_dest;

    dispatch_stage u_dispatch (.*);

    reservation_station u_rs (.*);

    execute_units u_exec (.*);  // drives the cdb seen by all

endmodule

/* tests/ooo_core_checker.sv */
module ooo_core_checker (
    input logic                                      clock,
    input logic                                      reset,
    input logic                                      alu_issue,
    input logic                                      alu_avail,
    input logic                                      mult_issue,
    input logic                                      almost_full,
    input logic [ooo_config_pkg::rs_count_width-1:0] count
);
    timeunit 1ns;
    timeprecision 100ps;
    import ooo_config_pkg::*;

    int violations;  // read by the testbench at the end

    initial violations = 0;

    count_bound: assert property (@(posedge clock) disable iff (reset)
        count <= rs_count_width'(rs_size))
    else begin
        $error("station count %0d above %0d entries", count, rs_size);
        violations++;
    end

    // multiply results own the cdb slot two cycles after issue
    alu_gated: assert property (@(posedge clock) disable iff (reset)
        mult_issue |-> ##2 (!alu_avail && !alu_issue))
    else begin
        $error("alu free to issue into the cycle a multiply result owns the cdb");
        violations++;
    end

    quiet_in_reset: assert property (@(posedge clock)
        reset |=> !alu_issue && !mult_issue && !almost_full)
    else begin
        $error("station outputs active during reset");
        violations++;
    end

endmodule

bind reservation_station ooo_core_checker rs_chk (
    .clock(clock),
    .reset(reset),
    .alu_issue(alu_issue),
    .alu_avail(alu_avail),
    .mult_issue(mult_issue),
    .almost_full(almost_full),
    .count(count)
);

/* tests/ooo_core_tb.sv */
module ooo_core_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import ooo_config_pkg::*;
    import ooo_isa_pkg::*;

    localparam int num_insts       = 24;
    localparam int clock_period    = 20;
    localparam int watchdog_cycles = num_insts * 20 + 200;
    localparam int burst_group     = 5;
    localparam int reorder_group   = 4;

    logic clock;
    logic reset;
    logic inst_valid;
    opcode_t inst_op;
    logic [reg_idx_width-1:0] inst_dest;
    logic [reg_idx_width-1:0] inst_src1;
    logic [reg_idx_width-1:0] inst_src2;
    logic stall;
    logic cdb_valid;
    logic [tag_width-1:0] cdb_tag;
    logic [reg_idx_width-1:0] cdb_dest;
    logic [data_width-1:0] cdb_value;

    // instruction table with expected results
    opcode_t t_op [num_insts];
    logic [reg_idx_width-1:0] t_dest [num_insts];
    logic [reg_idx_width-1:0] t_src1 [num_insts];
    logic [reg_idx_width-1:0] t_src2 [num_insts];
    int t_group [num_insts];
    logic [data_width-1:0] t_expect [num_insts];

    // scoreboard by tag
    logic sb_pending [num_tags];
    logic [data_width-1:0] sb_value [num_tags];
    logic [reg_idx_width-1:0] sb_dest [num_tags];
    int sb_group [num_tags];
    int sb_seq [num_tags];  // acceptance order

    int group_errors [7];
    int checks;
    int errors;
    int accepted;
    int completed;
    int seed;
    logic [tag_width-1:0] tb_tag;  // mirrors dispatch tag order
    logic stall_seen;
    int last_seq;
    logic reorder_seen;

    ooo_core dut (.*);

    always #(clock_period / 2) clock = ~clock;

    task automatic set_inst(input int i, input opcode_t op, input int d, input int s1,
                            input int s2, input int grp);
        t_op[i]    = op;
        t_dest[i]  = reg_idx_width'(d);
        t_src1[i]  = reg_idx_width'(s1);
        t_src2[i]  = reg_idx_width'(s2);
        t_group[i] = grp;
    endtask

    task automatic load_table();
        set_inst(0, op_add, 0, 1, 2, 2);   // independent alu
        set_inst(1, op_sub, 3, 7, 4, 2);
        set_inst(2, op_and, 6, 6, 5, 2);
        set_inst(3, op_add, 1, 2, 3, 3);   // alu into mul into alu
        set_inst(4, op_mul, 4, 1, 2, 3);
        set_inst(5, op_sub, 5, 4, 1, 3);
        set_inst(6, op_mul, 6, 6, 7, 4);   // slow mul, fast alu behind it
        set_inst(7, op_add, 7, 2, 3, 4);
        set_inst(8, op_xor, 0, 3, 4, 4);
        set_inst(9, op_mul, 1, 1, 1, 5);   // mul chain on r1
        set_inst(10, op_mul, 1, 1, 2, 5);
        set_inst(11, op_mul, 1, 1, 3, 5);
        set_inst(12, op_add, 2, 1, 0, 5);  // readers that fill the station
        set_inst(13, op_xor, 3, 1, 4, 5);
        set_inst(14, op_sub, 4, 1, 5, 5);
        set_inst(15, op_and, 5, 1, 6, 5);
        set_inst(16, op_add, 6, 1, 1, 5);
        set_inst(17, op_xor, 7, 1, 0, 5);
        set_inst(18, op_sub, 0, 1, 2, 5);
        set_inst(19, op_add, 2, 1, 3, 5);
        set_inst(20, op_and, 3, 1, 7, 5);  // held by the stall
        set_inst(21, op_mul, 5, 2, 3, 6);  // older writer finishes last
        set_inst(22, op_add, 5, 1, 1, 6);
        set_inst(23, op_xor, 6, 5, 0, 6);
    endtask

    function automatic logic [data_width-1:0] model_op(input opcode_t op,
                                                       input logic [data_width-1:0] a,
                                                       input logic [data_width-1:0] b);
        logic [data_width-1:0] r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_xor:  r = a ^ b;
            default: r = a * b;  // low half of the product
        endcase
        return r;
    endfunction

    function automatic string group_name(input int g);
        case (g)
            1:       return "reset state";
            2:       return "independent alu ops";
            3:       return "read after write chains";
            4:       return "out of order completion";
            5:       return "station full and stall";
            default: return "repeated writes";
        endcase
    endfunction

    // caller sits at a falling edge
    task automatic apply_inst(input int i);
        logic done;
        int gap;
        done = 1'b0;
        inst_valid = 1'b1;
        inst_op    = t_op[i];
        inst_dest  = t_dest[i];
        inst_src1  = t_src1[i];
        inst_src2  = t_src2[i];
        while (!done) begin
            #1;
            if (!stall) begin
                checks++;
                assert (!sb_pending[tb_tag]) else begin
                    $display("tag %0d handed out again before it completed", tb_tag);
                    errors++;
                    group_errors[t_group[i]]++;
                end
                sb_pending[tb_tag] = 1'b1;
                sb_value[tb_tag]   = t_expect[i];
                sb_dest[tb_tag]    = t_dest[i];
                sb_group[tb_tag]   = t_group[i];
                sb_seq[tb_tag]     = accepted;
                tb_tag = tb_tag + 1'b1;
                accepted++;
                done = 1'b1;
            end else begin
                stall_seen = 1'b1;
            end
            @(negedge clock);
        end
        inst_valid = 1'b0;
        gap = (t_group[i] == burst_group) ? 0 : ($random(seed) & 32'h7fff_ffff) % 3;
        repeat (gap) @(negedge clock);
    endtask

    task automatic run_group(input int g);
        stall_seen   = 1'b0;
        reorder_seen = 1'b0;
        for (int i = 0; i < num_insts; i++) begin
            if (t_group[i] == g) apply_inst(i);
        end
        while (completed != accepted) @(negedge clock);  // drain
        if (g == burst_group) begin
            checks++;
            assert (stall_seen) else begin
                $display("stall never rose while the burst filled the station");
                errors++;
                group_errors[g]++;
            end
        end
        if (g == reorder_group) begin
            checks++;
            assert (reorder_seen) else begin
                $display("no result overtook an older instruction on the cdb");
                errors++;
                group_errors[g]++;
            end
        end
        $display("behavior %0d %s: %0d errors", g, group_name(g), group_errors[g]);
    endtask

    // cdb monitor
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            checks++;
            assert (sb_pending[cdb_tag]) else begin
                $display("tag %0d appeared on the cdb with no instruction waiting on it",
                         cdb_tag);
                errors++;
            end
            if (sb_pending[cdb_tag]) begin
                assert (cdb_value == sb_value[cdb_tag] && cdb_dest == sb_dest[cdb_tag])
                else begin
                    $display("error: %0d ns: tag %0d gave dest %0d value %h, expected %0d %h",
                             $time, cdb_tag, cdb_dest, cdb_value, sb_dest[cdb_tag],
                             sb_value[cdb_tag]);
                    errors++;
                    group_errors[sb_group[cdb_tag]]++;
                end
                if (sb_seq[cdb_tag] < last_seq) begin
                    reorder_seen = 1'b1;  // overtook an older instruction
                end else begin
                    last_seq = sb_seq[cdb_tag];
                end
                sb_pending[cdb_tag] = 1'b0;
                completed++;
            end
        end
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("watchdog expired before all instructions completed");
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [data_width-1:0] model_regs [num_arch_regs];
        seed         = 30;
        clock        = 1'b0;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst_op      = op_add;
        inst_dest    = '0;
        inst_src1    = '0;
        inst_src2    = '0;
        checks       = 0;
        errors       = 0;
        accepted     = 0;
        completed    = 0;
        tb_tag       = '0;
        stall_seen   = 1'b0;
        last_seq     = 0;
        reorder_seen = 1'b0;
        for (int g = 0; g < 7; g++) group_errors[g] = 0;
        for (int t = 0; t < num_tags; t++) sb_pending[t] = 1'b0;
        load_table();
        // sequential model, register i starts at i
        for (int r = 0; r < num_arch_regs; r++) model_regs[r] = data_width'(r);
        for (int i = 0; i < num_insts; i++) begin
            t_expect[i] = model_op(t_op[i], model_regs[t_src1[i]], model_regs[t_src2[i]]);
            model_regs[t_dest[i]] = t_expect[i];
        end

        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        checks++;
        assert (!cdb_valid && !stall) else begin
            $display("error: %0d ns: cdb_valid or stall high right after reset", $time);
            errors++;
            group_errors[1]++;
        end
        $display("behavior 1 %s: %0d errors", group_name(1), group_errors[1]);

        for (int g = 2; g <= 6; g++) run_group(g);

        checks++;
        assert (dut.u_rs.rs_chk.violations == 0) else begin
            $display("station checker reported %0d assertion failures",
                     dut.u_rs.rs_chk.violations);
            errors++;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tb.f */
hdl/ooo_config_pkg.sv
hdl/ooo_isa_pkg.sv
hdl/dispatch_stage.sv
hdl/reservation_station.sv
hdl/execute_units.sv
hdl/ooo_core.sv
tests/ooo_core_checker.sv
tests/ooo_core_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = ooo_core_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Test passed$$" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
